/* outputPortUnit.f */
+incdir+verif
logic/nocPkg.sv
logic/holdTimer.sv
logic/outputArbiter.sv
logic/outputSwitch.sv
logic/outputPortUnit.sv
verif/outputPortUnitTb.sv

/* verif/outputPortModel.svh */
`ifndef OUTPUT_PORT_MODEL_SVH
`define OUTPUT_PORT_MODEL_SVH

// cycle model of the output port, stepped once per rising edge
int               modelHolder;  // granted port, -1 while idle
nocPkg::pktLength modelCount [nocPkg::numPorts];
nocPkg::pktLength modelLimit [nocPkg::numPorts];
nocPkg::flitWord  modelOutFlit;
logic             modelOutValid;

// one-hot code for a port index, anything else is idle
function automatic nocPkg::grantState grantOf(input int idx);
  nocPkg::grantState g;
  case (idx)
    0:       g = nocPkg::grantLocal;
    1:       g = nocPkg::grantNorth;
    2:       g = nocPkg::grantEast;
    3:       g = nocPkg::grantWest;
    4:       g = nocPkg::grantSouth;
    default: g = nocPkg::grantIdle;
  endcase
  return g;
endfunction

function automatic nocPkg::grantState modelGrant();
  return grantOf(modelHolder);
endfunction

// fixed priority from idle, local first
function automatic int firstFromIdle(input logic [nocPkg::numPorts-1:0] r);
  int pick;
  pick = -1;
  for (int k = nocPkg::numPorts - 1; k >= 0; k--)
  begin
    if (r[k])
      pick = k; // lowest index wins
  end
  return pick;
endfunction

// rotating search that starts after the holder and leaves it out
function automatic int firstAfter(input int h, input logic [nocPkg::numPorts-1:0] r);
  int pick;
  int idx;
  pick = -1;
  for (int k = nocPkg::numPorts - 1; k >= 1; k--)
  begin
    idx = (h + k) % nocPkg::numPorts;
    if (r[idx])
      pick = idx;
  end
  return pick;
endfunction

task automatic modelReset();
  modelHolder = -1;
  modelOutFlit = '0;
  modelOutValid = 1'b0;
  for (int k = 0; k < nocPkg::numPorts; k++)
  begin
    modelCount[k] = '0;
    modelLimit[k] = '0;
  end
endtask

task automatic modelStep(
  input logic                                   rstNow,
  input logic [nocPkg::numPorts-1:0]            r,
  input nocPkg::flitWord [nocPkg::numPorts-1:0] f,
  input logic [nocPkg::numPorts-1:0]            v
);
  int                          nextHolder;
  logic [nocPkg::numPorts-1:0] runNow;
  if (rstNow)
    modelReset();
  else
  begin
    runNow = '0;
    if (modelHolder < 0)
      nextHolder = firstFromIdle(r);
    else if (r[modelHolder] && (modelCount[modelHolder] != modelLimit[modelHolder]))
    begin
      nextHolder = modelHolder;
      runNow[modelHolder] = 1'b1;
    end
    else
      nextHolder = firstAfter(modelHolder, r);
    // link register follows the grant of this cycle
    if (modelHolder < 0)
      modelOutValid = 1'b0;
    else
    begin
      modelOutValid = v[modelHolder];
      if (v[modelHolder])
        modelOutFlit = f[modelHolder];
    end
    for (int k = 0; k < nocPkg::numPorts; k++)
    begin
      if (v[k] && (f[k].kind == nocPkg::kindHead))
        modelLimit[k] = f[k].payload[11:0];
      modelCount[k] = runNow[k] ? modelCount[k] + 1'b1 : '0;
    end
    modelHolder = nextHolder;
  end
endtask

`endif

/* verif/outputPortUnitTb.sv */
`timescale 1ns/1ps

module outputPortUnitTb;

  localparam int resetCycles    = 16;
  localparam int startCycles    = 10;
  localparam int singleRounds   = nocPkg::numPorts;
  localparam int priorityRounds = 40;
  localparam int rotateRounds   = 40;
  localparam int holdRounds     = 24;
  localparam int randomCycles   = 3000;
  localparam int cycleLimit     = resetCycles + startCycles + singleRounds * 8
                                  + priorityRounds * 6 + rotateRounds * 8
                                  + holdRounds * 32 + randomCycles + 100;

  logic                                   clk;
  logic                                   rst;
  logic [nocPkg::numPorts-1:0]            reqs;
  nocPkg::flitWord [nocPkg::numPorts-1:0] inFlits;
  logic [nocPkg::numPorts-1:0]            inValids;
  nocPkg::grantState                      grant;
  nocPkg::flitWord                        outFlit;
  logic                                   outValid;

  int seed = 41;
  int cycleCount = 0;

  `include "outputPortModel.svh"

  outputPortUnit dut (
    .clk      (clk),
    .rst      (rst),
    .reqs     (reqs),
    .inFlits  (inFlits),
    .inValids (inValids),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic checkGrant(input nocPkg::grantState expected, input nocPkg::grantState actual);
    if (actual !== expected)
      abortRun($sformatf("ERROR grant expected %h actual %h", expected, actual));
  endtask

  task automatic checkFlit(
    input nocPkg::flitWord expFlit,
    input logic            expValid,
    input nocPkg::flitWord actFlit,
    input logic            actValid
  );
    if (actValid !== expValid)
      abortRun($sformatf("ERROR outValid expected %h actual %h", expValid, actValid));
    else if (expValid && (actFlit !== expFlit))
      abortRun($sformatf("ERROR outFlit expected %h actual %h", expFlit, actFlit));
  endtask

  task automatic checkHold(input int expected, input int actual);
    if (actual !== expected)
      abortRun($sformatf("ERROR hold cycles expected %h actual %h", expected, actual));
  endtask

  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit)
      abortRun("timeout: the run went past its cycle limit");
  end

  always @(posedge clk)
    modelStep(rst, reqs, inFlits, inValids); // sees the values applied for this cycle

  always @(negedge clk)
  begin
    if (!rst)
    begin
      checkGrant(modelGrant(), grant);
      checkFlit(modelOutFlit, modelOutValid, outFlit, outValid);
    end
  end

  function automatic logic [nocPkg::numPorts-1:0] onePort(input int p);
    logic [nocPkg::numPorts-1:0] r;
    r = '0;
    r[p] = 1'b1;
    return r;
  endfunction

  task automatic applyCycle(
    input logic [nocPkg::numPorts-1:0]            r,
    input nocPkg::flitWord [nocPkg::numPorts-1:0] f,
    input logic [nocPkg::numPorts-1:0]            v
  );
    @(posedge clk);
    reqs     <= r;
    inFlits  <= f;
    inValids <= v;
  endtask

  task automatic goIdle();
    repeat (3) applyCycle('0, '0, '0);
  endtask

  task automatic randomBits(output logic [nocPkg::numPorts-1:0] r);
    int raw;
    raw = $random(seed);
    r = raw[nocPkg::numPorts-1:0];
  endtask

  task automatic makeFlit(output nocPkg::flitWord w);
    int pick;
    pick = $unsigned($random(seed)) % 3;
    w.payload = $random(seed);
    w.kind = (pick == 0) ? nocPkg::kindHead : (pick == 1) ? nocPkg::kindBody : nocPkg::kindTail;
    if (w.kind == nocPkg::kindHead)
      w.payload[11:0] = $unsigned($random(seed)) % 24; // short holds so releases happen
  endtask

  // head flit sets the limit, then p requests without a break
  task automatic holdRound(input int p, input int q, input int len);
    nocPkg::flitWord [nocPkg::numPorts-1:0] f;
    nocPkg::flitWord                        head;
    logic [nocPkg::numPorts-1:0]            r;
    int                                     held;
    logic                                   done;
    head.kind = nocPkg::kindHead;
    head.payload = $random(seed);
    head.payload[11:0] = len[11:0];
    f = '0;
    f[p] = head;
    goIdle();
    applyCycle('0, f, onePort(p));
    applyCycle(onePort(p), '0, '0);
    held = 0;
    done = 1'b0;
    while (!done)
    begin
      @(negedge clk);
      if (grant == grantOf(p))
        held++;
      else if (held > 0)
        done = 1'b1;
      if (!done)
      begin
        r = onePort(p);
        if ((held > 0) && (q >= 0))
          r[q] = 1'b1; // competitor shows up during the hold
        applyCycle(r, '0, '0);
      end
    end
    checkHold(len + 1, held);
    if (q >= 0)
      checkGrant(grantOf(q), grant);
    else
    begin
      checkGrant(nocPkg::grantIdle, grant);
      @(negedge clk);
      checkGrant(grantOf(p), grant);
    end
  endtask

  initial
  begin
    logic [nocPkg::numPorts-1:0]            r;
    logic [nocPkg::numPorts-1:0]            v;
    nocPkg::flitWord [nocPkg::numPorts-1:0] f;
    int                                     h;
    int                                     q;
    rst = 1'b1;
    reqs = '0;
    inFlits = '0;
    inValids = '0;
    repeat (resetCycles) @(posedge clk);
    rst <= 1'b0;

    repeat (8)
    begin
      @(negedge clk);
      checkGrant(nocPkg::grantIdle, grant);
      checkFlit('0, 1'b0, outFlit, outValid);
    end

    for (int p = 0; p < singleRounds; p++)
    begin
      goIdle();
      applyCycle(onePort(p), '0, '0);
      @(posedge clk);
      @(negedge clk);
      checkGrant(grantOf(p), grant);
    end

    for (int n = 0; n < priorityRounds; n++)
    begin
      randomBits(r);
      if (r == '0)
        r = onePort(nocPkg::numPorts - 1);
      goIdle();
      applyCycle(r, '0, '0);
      @(posedge clk);
      @(negedge clk);
      checkGrant(grantOf(firstFromIdle(r)), grant);
    end

    for (int n = 0; n < rotateRounds; n++)
    begin
      if (n == 0)
      begin
        h = 3;
        r = 5'b10001; // west releases with south and local waiting
      end
      else
      begin
        h = $unsigned($random(seed)) % nocPkg::numPorts;
        randomBits(r);
        r[h] = 1'b0;
        if (r == '0)
          r = onePort((h + 2) % nocPkg::numPorts);
      end
      goIdle();
      applyCycle(onePort(h), '0, '0);
      applyCycle(r, '0, '0);
      @(posedge clk);
      @(negedge clk);
      checkGrant(grantOf(firstAfter(h, r)), grant);
      if (n == 0)
        checkGrant(nocPkg::grantSouth, grant);
    end

    for (int n = 0; n < holdRounds; n++)
    begin
      h = $unsigned($random(seed)) % nocPkg::numPorts;
      q = -1;
      if (n % 2)
        q = (h + 1 + $unsigned($random(seed)) % 4) % nocPkg::numPorts;
      holdRound(h, q, 3 + $unsigned($random(seed)) % 18);
    end

    // mixed traffic, checked against the model on every cycle
    for (int n = 0; n < randomCycles; n++)
    begin
      for (int k = 0; k < nocPkg::numPorts; k++)
        makeFlit(f[k]);
      randomBits(r);
      randomBits(v);
      applyCycle(r, f, v);
    end

    repeat (2) @(negedge clk);
    $display("TEST PASS");
    $finish;
  end

endmodule

/* logic/outputPortUnit.sv */
`timescale 1ns/1ps

// one output port of the five-port mesh router
module outputPortUnit
(
  input  logic                                     clk,
  input  logic                                     rst,
  input  logic [nocPkg::numPorts-1:0]              reqs,
  input  nocPkg::flitWord [nocPkg::numPorts-1:0]   inFlits,
  input  logic [nocPkg::numPorts-1:0]              inValids,
  output nocPkg::grantState                        grant,
  output nocPkg::flitWord                          outFlit,
  output logic                                     outValid
);

  // grant feeds the switch and leaves the unit as well
  outputArbiter arbiter (
    .clk      (clk),
    .rst      (rst),
    .reqs     (reqs),
    .inFlits  (inFlits),
    .inValids (inValids),
    .grant    (grant)
  );

  outputSwitch switch (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .inFlits  (inFlits),
    .inValids (inValids),
    .outFlit  (outFlit),
    .outValid (outValid)   // registered, one cycle behind grant
  );

endmodule

/* logic/outputSwitch.sv */
`timescale 1ns/1ps

module outputSwitch
(
  input  logic                                     clk,
  input  logic                                     rst,
  input  nocPkg::grantState                        grant,
  input  nocPkg::flitWord [nocPkg::numPorts-1:0]   inFlits,
  input  logic [nocPkg::numPorts-1:0]              inValids,
  output nocPkg::flitWord                          outFlit,
  output logic                                     outValid
);

  nocPkg::portId sel;
  logic          granted;

  assign sel = nocPkg::toPort(grant); // one-hot to index
  assign granted = (grant != nocPkg::grantIdle);

  // strobe goes out one cycle after the granted port's valid
  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= granted && inValids[sel];
  end

  // link register keeps its last flit while idle
  always_ff @(posedge clk)
  begin
    if (granted)
      outFlit <= inFlits[sel];
  end

endmodule

/* logic/outputArbiter.sv */
`timescale 1ns/1ps

module outputArbiter
(
  input  logic                                     clk,
  input  logic                                     rst,
  input  logic [nocPkg::numPorts-1:0]              reqs,
  input  nocPkg::flitWord [nocPkg::numPorts-1:0]   inFlits,
  input  logic [nocPkg::numPorts-1:0]              inValids,
  output nocPkg::grantState                        grant
);

  nocPkg::grantState               nextGrant;
  nocPkg::portId                   holder;
  logic [nocPkg::numPorts-1:0]     runs;
  logic [nocPkg::numPorts-1:0]     timesUps;

  // first requester found from start onward, looking at span ports with wrap
  function automatic nocPkg::grantState firstReq(
    input logic [nocPkg::numPorts-1:0] req,
    input int unsigned                 start,
    input int unsigned                 span
  );
    nocPkg::grantState pick;
    int unsigned       idx;
    logic              found;
    pick = nocPkg::grantIdle;
    found = 1'b0;
    for (int unsigned k = 0; k < nocPkg::numPorts; k++)
    begin
      idx = (start + k) % nocPkg::numPorts;
      if (!found && (k < span) && req[idx])
      begin
        pick = nocPkg::toGrant(nocPkg::portId'(idx));
        found = 1'b1;
      end
    end
    return pick;
  endfunction

  // one timer per input port
  for (genvar p = 0; p < nocPkg::numPorts; p++)
  begin : gTimer
    holdTimer timer (
      .clk       (clk),
      .rst       (rst),
      .flit      (inFlits[p]),
      .flitValid (inValids[p]),
      .run       (runs[p]),
      .timesUp   (timesUps[p])
    );
  end

  assign holder = nocPkg::toPort(grant);

  always_ff @(posedge clk)
  begin
    if (rst)
      grant <= nocPkg::grantIdle;
    else
      grant <= nextGrant;
  end

  always_comb
  begin
    runs = '0;
    if (grant == nocPkg::grantIdle)
    begin
      // fixed priority from idle
      nextGrant = firstReq(reqs, 0, nocPkg::numPorts);
    end
    else if (reqs[holder] && !timesUps[holder])
    begin
      nextGrant = grant;
      runs[holder] = 1'b1;
    end
    else
    begin
      // rotate past the holder, which is left out of the search
      nextGrant = firstReq(reqs, holder + 1, nocPkg::numPorts - 1);
    end
  end

  legalGrant: assert property (
    @(posedge clk) disable iff (rst)
    $onehot(grant)
  )
  else
    $error("grant is not a legal one-hot state: %h", grant);

  // timers only run for the port that owns the link
  runOnlyWhenGranted: assert property (
    @(posedge clk) disable iff (rst)
    (runs & ~grant[nocPkg::numPorts:1]) == '0
  )
  else
    $error("timer running for a port without the grant: %h", runs);

  // a new owner must have been requesting in the cycle before
  grantFollowsReq: assert property (
    @(posedge clk) disable iff (rst)
    (grant != nocPkg::grantIdle) && (grant != $past(grant))
      |-> (($past(reqs) & grant[nocPkg::numPorts:1]) != '0)
  )
  else
    $error("grant moved to a port that was not requesting");

endmodule

/* logic/holdTimer.sv */
`timescale 1ns/1ps

module holdTimer
(
  input  logic            clk,
  input  logic            rst,
  input  nocPkg::flitWord flit,
  input  logic            flitValid,
  input  logic            run,
  output logic            timesUp
);

  nocPkg::pktLength limit;
  nocPkg::pktLength count;
  logic             headSeen;

  assign headSeen = flitValid && (flit.kind == nocPkg::kindHead);

  // limit follows the most recent head flit on this port
  always_ff @(posedge clk)
  begin
    if (rst)
      limit <= '0;
    else if (headSeen)
      limit <= flit.payload[$bits(nocPkg::pktLength)-1:0];
  end

  // cycles spent holding the grant
  always_ff @(posedge clk)
  begin
    if (rst)
      count <= '0;
    else if (!run)
      count <= '0;
    else
      count <= count + 1'b1;
  end

  assign timesUp = (count == limit);

  // the arbiter drops run once the limit is reached, so the count never steps over it
  runStopsAtLimit: assert property (
    @(posedge clk) disable iff (rst)
    run |-> (count != limit)
  )
  else
    $error("hold counter stepped past its limit");

endmodule

/* logic/nocPkg.sv */
package nocPkg;

  localparam int numPorts = 5;

  // input ports, listed in fixed priority order
  typedef enum logic [2:0] {
    portLocal,
    portNorth,
    portEast,
    portWest,
    portSouth
  } portId;

  // one-hot grant, idle in the lowest bit
  typedef enum logic [5:0] {
    grantIdle  = 6'b000001,
    grantLocal = 6'b000010,
    grantNorth = 6'b000100,
    grantEast  = 6'b001000,
    grantWest  = 6'b010000,
    grantSouth = 6'b100000
  } grantState;

  typedef logic [2:0] flitKind;
  typedef logic [11:0] pktLength; // hold limit in cycles

  localparam flitKind kindHead = 3'd1;
  localparam flitKind kindBody = 3'd2;
  localparam flitKind kindTail = 3'd3;

  typedef struct packed {
    flitKind     kind;
    logic [31:0] payload; // low bits carry the length in a head flit
  } flitWord;

  // hold state of a port
  function automatic grantState toGrant(portId p);
    return grantState'(6'b000010 << p);
  endfunction

  // port named by a grant, idle falls back to local
  function automatic portId toPort(grantState g);
    portId p;
    case (g)
      grantNorth: p = portNorth;
      grantEast:  p = portEast;
      grantWest:  p = portWest;
      grantSouth: p = portSouth;
      default:    p = portLocal;
    endcase
    return p;
  endfunction

endpackage
